// File: Bender.yml
package:
  name: trap_ctrl

sources:
  - source/trap_pkg.sv
  - source/trap_cause_sel.sv
  - source/trap_sequencer.sv
  - source/machine_csr_regs.sv
  - source/trap_ctrl_top.sv
  - target: test
    files:
      - testbench/trap_ctrl_checker.sv
      - testbench/trap_ctrl_tb.sv

// File: build.f
source/trap_pkg.sv
source/trap_cause_sel.sv
source/trap_sequencer.sv
source/machine_csr_regs.sv
source/trap_ctrl_top.sv
testbench/trap_ctrl_checker.sv
testbench/trap_ctrl_tb.sv

// File: source/machine_csr_regs.sv
//**********************************************************************
// machine CSR bank
// holds mstatus, mtvec, mepc and mcause, takes sequencer writes and
// serves a Wishbone classic slave port
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module machine_csr_regs import trap_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_MTVEC = 32'h0000_0100
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire csr_wr_t         csr_wr_i,
    input  wire logic            seq_busy_i,
    input  wire wb_req_t         wb_req_i,
    output wb_rsp_t              wb_rsp_o,
    output mstatus_t             mstatus_o,
    output logic [XLEN-1:0]      mtvec_o,
    output logic [XLEN-1:0]      mepc_o
);

    mstatus_t              mstatus_q;
    logic [XLEN-1:0]       mtvec_q;
    logic [XLEN-1:0]       mepc_q;
    mcause_t               mcause_q;
    logic                  ack_q;
    logic [XLEN-1:0]       rdata_q;
    logic                  bus_req;
    logic                  bus_ok;
    logic                  bus_wr;
    logic                  wr_en;
    logic [CSR_ADDR_W-1:0] wr_addr;
    logic [XLEN-1:0]       wr_data;
    mstatus_t              wr_status;
    logic [XLEN-1:0]       rd_data;

    // new bus cycle, not yet acknowledged
    assign bus_req = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    // writes wait for the trap sequence to finish, reads never do
    assign bus_ok  = bus_req & (~wb_req_i.we | ~seq_busy_i);
    assign bus_wr  = bus_ok & wb_req_i.we;

    // single write port, sequencer only writes while the bus is held off
    always_comb begin
        if (csr_wr_i.we) begin
            wr_en   = 1'b1;
            wr_addr = csr_wr_i.addr;
            wr_data = csr_wr_i.data;
        end else begin
            wr_en   = bus_wr;
            wr_addr = wb_req_i.adr;
            wr_data = wb_req_i.dat_w;
        end
    end

    assign wr_status = mstatus_t'(wr_data);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q <= '0;
            mtvec_q   <= RESET_MTVEC;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (wr_en) begin
            case (wr_addr)
                CSR_MSTATUS: begin
                    // only mie and mpie are implemented
                    mstatus_q.mie  <= wr_status.mie;
                    mstatus_q.mpie <= wr_status.mpie;
                end
                CSR_MTVEC:  mtvec_q  <= wr_data;
                CSR_MEPC:   mepc_q   <= wr_data;
                CSR_MCAUSE: mcause_q <= mcause_t'(wr_data);
                default:    ;   // unknown address, write dropped
            endcase
        end
    end

    always_comb begin
        case (wb_req_i.adr)
            CSR_MSTATUS: rd_data = mstatus_q;
            CSR_MTVEC:   rd_data = mtvec_q;
            CSR_MEPC:    rd_data = mepc_q;
            CSR_MCAUSE:  rd_data = mcause_q;
            default:     rd_data = '0;
        endcase
    end

    // one-cycle ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (bus_ok) begin
            rdata_q <= rd_data;   // valid alongside ack
        end
    end

    assign wb_rsp_o.ack   = ack_q;
    assign wb_rsp_o.dat_r = rdata_q;
    assign mstatus_o      = mstatus_q;
    assign mtvec_o        = mtvec_q;
    assign mepc_o         = mepc_q;

endmodule

`default_nettype wire

// File: source/trap_cause_sel.sv
//**********************************************************************
// trap cause selector
// prioritizes ecall, ebreak and interrupts, builds the return address
// and tracks whether the core is running an interrupt handler
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module trap_cause_sel import trap_pkg::*; #(
    parameter int IRQ_ID_W = 8
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                inst_valid_i,
    input  wire logic                ecall_i,
    input  wire logic                ebreak_i,
    input  wire logic [XLEN-1:0]     pc_i,
    input  wire logic                jump_flag_i,
    input  wire logic [XLEN-1:0]     jump_addr_i,
    input  wire logic                irq_i,
    input  wire logic [IRQ_ID_W-1:0] irq_id_i,
    input  wire mstatus_t            mstatus_i,
    input  wire logic                trap_take_i,
    input  wire logic                mret_take_i,
    output trap_req_t                req_o
);

    logic                in_irq_q;  // inside an interrupt handler
    logic [IRQ_ID_W-1:0] irq_id_q;  // id taken at handler entry
    logic                irq_ok;
    logic [XLEN-1:0]     ret_addr;
    logic [30:0]         irq_code;

    // a repeat of the running id is held off until mret
    assign irq_ok = inst_valid_i & irq_i & mstatus_i.mie &
                    (~in_irq_q | (irq_id_i != irq_id_q));

    // pending jump means the faulting slot sits just before the target
    assign ret_addr = jump_flag_i ? (jump_addr_i - XLEN'(4)) : pc_i;
    assign irq_code = 31'(IRQ_CAUSE_BASE) + 31'(irq_id_i);

    always_comb begin
        req_o     = '0;
        req_o.epc = ret_addr;
        if (ecall_i) begin
            req_o.valid      = 1'b1;
            req_o.cause.code = CAUSE_ECALL;
        end else if (ebreak_i) begin
            req_o.valid      = 1'b1;
            req_o.cause.code = CAUSE_EBREAK;
        end else if (irq_ok) begin
            req_o.valid      = 1'b1;
            req_o.is_irq     = 1'b1;
            req_o.cause.irq  = 1'b1;
            req_o.cause.code = irq_code;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_irq_q <= 1'b0;
            irq_id_q <= '0;
        end else if (trap_take_i && req_o.is_irq) begin
            in_irq_q <= 1'b1;
            irq_id_q <= irq_id_i;   // remember who we are serving
        end else if (mret_take_i) begin
            in_irq_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/trap_ctrl_top.sv
//**********************************************************************
// machine-mode trap controller top level
// cause selector, trap sequencer and machine CSR bank
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl_top import trap_pkg::*; #(
    parameter int              IRQ_ID_W    = 8,
    parameter logic [XLEN-1:0] RESET_MTVEC = 32'h0000_0100
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                inst_valid_i,
    input  wire logic [XLEN-1:0]     pc_i,
    input  wire logic                jump_flag_i,
    input  wire logic [XLEN-1:0]     jump_addr_i,
    input  wire logic                ecall_i,
    input  wire logic                ebreak_i,
    input  wire logic                mret_i,
    input  wire logic                atom_busy_i,
    input  wire logic                irq_i,
    input  wire logic [IRQ_ID_W-1:0] irq_id_i,
    input  wire wb_req_t             wb_req_i,
    output wb_rsp_t                  wb_rsp_o,
    output logic                     flush_o,
    output logic                     stall_o,
    output logic                     redirect_o,
    output logic [XLEN-1:0]          redirect_addr_o
);

    trap_req_t       trap_req;
    logic            trap_take;
    logic            mret_take;
    csr_wr_t         csr_wr;
    logic            seq_busy;
    mstatus_t        mstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;

    trap_cause_sel #(
        .IRQ_ID_W (IRQ_ID_W)
    ) cause_sel_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid_i (inst_valid_i),
        .ecall_i      (ecall_i),
        .ebreak_i     (ebreak_i),
        .pc_i         (pc_i),
        .jump_flag_i  (jump_flag_i),
        .jump_addr_i  (jump_addr_i),
        .irq_i        (irq_i),
        .irq_id_i     (irq_id_i),
        .mstatus_i    (mstatus),
        .trap_take_i  (trap_take),
        .mret_take_i  (mret_take),
        .req_o        (trap_req)
    );

    trap_sequencer sequencer_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_i           (trap_req),
        .ecall_i         (ecall_i),
        .ebreak_i        (ebreak_i),
        .mret_i          (mret_i),
        .atom_busy_i     (atom_busy_i),
        .mstatus_i       (mstatus),
        .mtvec_i         (mtvec),
        .mepc_i          (mepc),
        .trap_take_o     (trap_take),
        .mret_take_o     (mret_take),
        .csr_wr_o        (csr_wr),
        .busy_o          (seq_busy),
        .flush_o         (flush_o),
        .stall_o         (stall_o),
        .redirect_o      (redirect_o),
        .redirect_addr_o (redirect_addr_o)
    );

    machine_csr_regs #(
        .RESET_MTVEC (RESET_MTVEC)
    ) csr_regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr_wr_i   (csr_wr),
        .seq_busy_i (seq_busy),   // bus writes wait for the sequence
        .wb_req_i   (wb_req_i),
        .wb_rsp_o   (wb_rsp_o),
        .mstatus_o  (mstatus),
        .mtvec_o    (mtvec),
        .mepc_o     (mepc)
    );

endmodule

`default_nettype wire

// File: source/trap_pkg.sv
//**********************************************************************
// trap controller shared definitions
// widths, machine CSR addresses, cause codes and bundled signal types
//**********************************************************************
`default_nettype none

package trap_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // machine CSR addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;

    // synchronous exception codes
    localparam logic [30:0] CAUSE_ECALL  = 31'd11;
    localparam logic [30:0] CAUSE_EBREAK = 31'd3;

    // interrupt code is base plus id
    localparam int IRQ_CAUSE_BASE = 16;

    typedef struct packed {
        logic [23:0] rsvd_hi;
        logic        mpie;     // bit 7
        logic [2:0]  rsvd_mid;
        logic        mie;      // bit 3
        logic [2:0]  rsvd_lo;
    } mstatus_t;

    typedef struct packed {
        logic        irq;
        logic [30:0] code;
    } mcause_t;

    typedef struct packed {
        logic            valid;
        logic            is_irq;
        mcause_t         cause;
        logic [XLEN-1:0] epc;   // return address to save
    } trap_req_t;

    typedef struct packed {
        logic                  we;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } csr_wr_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [CSR_ADDR_W-1:0] adr;
        logic [XLEN-1:0]       dat_w;
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: source/trap_sequencer.sv
//**********************************************************************
// trap sequencer
// one-hot FSM that saves state into the machine CSRs on a trap,
// restores mie on mret and then redirects the fetch unit
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module trap_sequencer import trap_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire trap_req_t       req_i,
    input  wire logic            ecall_i,
    input  wire logic            ebreak_i,
    input  wire logic            mret_i,
    input  wire logic            atom_busy_i,
    input  wire mstatus_t        mstatus_i,
    input  wire logic [XLEN-1:0] mtvec_i,
    input  wire logic [XLEN-1:0] mepc_i,
    output logic                 trap_take_o,
    output logic                 mret_take_o,
    output csr_wr_t              csr_wr_o,
    output logic                 busy_o,
    output logic                 flush_o,
    output logic                 stall_o,
    output logic                 redirect_o,
    output logic [XLEN-1:0]      redirect_addr_o
);

    // one-hot state bit positions
    localparam int S_IDLE    = 0;
    localparam int S_MEPC    = 1;
    localparam int S_MSTATUS = 2;
    localparam int S_MCAUSE  = 3;
    localparam int S_MRET    = 4;
    localparam int S_JUMP    = 5;
    localparam int S_REDIR   = 6;
    localparam int N_STATES  = 7;

    logic [N_STATES-1:0] state_q;
    logic [N_STATES-1:0] state_d;
    logic                is_mret_q;   // current sequence is a return
    logic [XLEN-1:0]     epc_q;
    mcause_t             cause_q;
    logic [XLEN-1:0]     target_q;
    logic                idle;
    logic                sync_hold;
    logic                trap_go;
    logic                mret_go;
    mstatus_t            mstatus_trap;
    mstatus_t            mstatus_mret;

    assign idle = state_q[S_IDLE];

    // ecall / ebreak wait for the atomic unit to drain
    assign sync_hold = req_i.valid & ~req_i.is_irq & atom_busy_i;
    assign trap_go   = idle & req_i.valid & ~sync_hold;
    assign mret_go   = idle & mret_i & ~req_i.valid;    // traps win

    always_comb begin
        state_d = '0;
        case (1'b1)
            state_q[S_IDLE]: begin
                if (trap_go) begin
                    state_d[S_MEPC] = 1'b1;
                end else if (mret_go) begin
                    state_d[S_MRET] = 1'b1;
                end else begin
                    state_d[S_IDLE] = 1'b1;
                end
            end
            state_q[S_MEPC]:    state_d[S_MSTATUS] = 1'b1;
            state_q[S_MSTATUS]: state_d[S_MCAUSE]  = 1'b1;
            state_q[S_MCAUSE]:  state_d[S_JUMP]    = 1'b1;
            state_q[S_MRET]:    state_d[S_JUMP]    = 1'b1;
            state_q[S_JUMP]:    state_d[S_REDIR]   = 1'b1;
            default:            state_d[S_IDLE]    = 1'b1;  // also recovers bad encodings
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= N_STATES'(1) << S_IDLE;
            is_mret_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (idle) begin
                is_mret_q <= mret_go;
            end
        end
    end

    // saved trap context and jump target
    always_ff @(posedge clk) begin
        if (trap_go) begin
            epc_q   <= req_i.epc;
            cause_q <= req_i.cause;
        end
        if (state_q[S_JUMP]) begin
            target_q <= is_mret_q ? mepc_i : mtvec_i;
        end
    end

    always_comb begin
        mstatus_trap      = mstatus_i;
        mstatus_trap.mpie = mstatus_i.mie;
        mstatus_trap.mie  = 1'b0;
        mstatus_mret      = mstatus_i;
        mstatus_mret.mie  = mstatus_i.mpie;
        mstatus_mret.mpie = 1'b1;

        csr_wr_o = '0;
        if (state_q[S_MEPC]) begin
            csr_wr_o.we   = 1'b1;
            csr_wr_o.addr = CSR_MEPC;
            csr_wr_o.data = epc_q;
        end else if (state_q[S_MSTATUS]) begin
            csr_wr_o.we   = 1'b1;
            csr_wr_o.addr = CSR_MSTATUS;
            csr_wr_o.data = mstatus_trap;
        end else if (state_q[S_MCAUSE]) begin
            csr_wr_o.we   = 1'b1;
            csr_wr_o.addr = CSR_MCAUSE;
            csr_wr_o.data = cause_q;
        end else if (state_q[S_MRET]) begin
            csr_wr_o.we   = 1'b1;
            csr_wr_o.addr = CSR_MSTATUS;
            csr_wr_o.data = mstatus_mret;
        end
    end

    assign trap_take_o     = trap_go;
    assign mret_take_o     = mret_go;
    assign busy_o          = ~idle;
    assign flush_o         = ~idle;   // held through the redirect cycle
    assign stall_o         = (ecall_i | ebreak_i) & atom_busy_i;
    assign redirect_o      = state_q[S_REDIR];
    assign redirect_addr_o = target_q;

endmodule

`default_nettype wire

// File: testbench/trap_ctrl_checker.sv
//**********************************************************************
// trap controller protocol checker
// concurrent assertions on redirect timing, bus ack and reset state
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl_checker import trap_pkg::*; (
    input wire logic    clk,
    input wire logic    rst_n,
    input wire logic    trap_take_i,
    input wire logic    mret_take_i,
    input wire logic    flush_i,
    input wire logic    stall_i,
    input wire logic    redirect_i,
    input wire wb_req_t wb_req_i,
    input wire wb_rsp_t wb_rsp_i
);

    int fail_cnt = 0;   // failure tally

    // trap entry, four flush cycles before the redirect
    property trap_redirect_p;
        @(posedge clk) disable iff (!rst_n)
        $rose(flush_i) && $past(trap_take_i) |-> !redirect_i [*4] ##1 redirect_i;
    endproperty

    // mret, two flush cycles before the redirect
    property mret_redirect_p;
        @(posedge clk) disable iff (!rst_n)
        $rose(flush_i) && $past(mret_take_i) |-> !redirect_i [*2] ##1 redirect_i;
    endproperty

    property redirect_pulse_p;
        @(posedge clk) disable iff (!rst_n)
        redirect_i |=> !redirect_i && !flush_i;
    endproperty

    property ack_in_cycle_p;
        @(posedge clk) disable iff (!rst_n)
        wb_rsp_i.ack |-> wb_req_i.cyc && wb_req_i.stb;
    endproperty

    property ack_single_p;
        @(posedge clk) disable iff (!rst_n)
        wb_rsp_i.ack |=> !wb_rsp_i.ack;
    endproperty

    property stall_blocks_take_p;
        @(posedge clk) disable iff (!rst_n)
        stall_i |-> !trap_take_i;
    endproperty

    // first edge out of reset
    property reset_quiet_p;
        @(posedge clk)
        $rose(rst_n) |-> !flush_i && !redirect_i && !stall_i && !wb_rsp_i.ack;
    endproperty

    trap_redirect_a: assert property (trap_redirect_p)
        else begin
            fail_cnt++;
            $error("trap redirect is not 4 cycles after the flush rise");
        end

    mret_redirect_a: assert property (mret_redirect_p)
        else begin
            fail_cnt++;
            $error("mret redirect is not 2 cycles after the flush rise");
        end

    redirect_pulse_a: assert property (redirect_pulse_p)
        else begin
            fail_cnt++;
            $error("redirect longer than one cycle or flush still high after it");
        end

    ack_in_cycle_a: assert property (ack_in_cycle_p)
        else begin
            fail_cnt++;
            $error("ack outside of a bus cycle");
        end

    ack_single_a: assert property (ack_single_p)
        else begin
            fail_cnt++;
            $error("ack held for more than one cycle");
        end

    stall_blocks_take_a: assert property (stall_blocks_take_p)
        else begin
            fail_cnt++;
            $error("trap accepted while stalled on the atomic unit");
        end

    reset_quiet_a: assert property (reset_quiet_p)
        else begin
            fail_cnt++;
            $error("outputs not low after reset");
        end

endmodule

bind trap_ctrl_top trap_ctrl_checker chk_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .trap_take_i (trap_take),
    .mret_take_i (mret_take),
    .flush_i     (flush_o),
    .stall_i     (stall_o),
    .redirect_i  (redirect_o),
    .wb_req_i    (wb_req_i),
    .wb_rsp_i    (wb_rsp_o)
);

`default_nettype wire

// File: testbench/trap_ctrl_tb.sv
//**********************************************************************
// trap controller testbench
// drives traps, interrupts, mret and Wishbone traffic into the top level
// and checks the saved CSR state through bus readback
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl_tb import trap_pkg::*; ();

    localparam int              IRQ_ID_W     = 8;
    localparam logic [XLEN-1:0] RESET_MTVEC  = 32'h0000_0100;
    localparam int              N_TESTS      = 7;
    localparam int              WATCHDOG_CYC = N_TESTS * 200;
    localparam int              WAIT_LIMIT   = 32;   // per handshake

    logic                clk;
    logic                rst_n;
    logic                inst_valid_i;
    logic [XLEN-1:0]     pc_i;
    logic                jump_flag_i;
    logic [XLEN-1:0]     jump_addr_i;
    logic                ecall_i;
    logic                ebreak_i;
    logic                mret_i;
    logic                atom_busy_i;
    logic                irq_i;
    logic [IRQ_ID_W-1:0] irq_id_i;
    wb_req_t             wb_req;
    wb_rsp_t             wb_rsp;
    logic                flush;
    logic                stall;
    logic                redirect;
    logic [XLEN-1:0]     redirect_addr;

    int              errors;
    int              hs_errors;        // handshakes that never came
    int              redirect_cnt = 0;
    logic [XLEN-1:0] last_redirect_addr;
    logic            flush_at_ack;
    logic [31:0]     lfsr_q;
    logic            exp_mie;          // reference model of mstatus
    logic            exp_mpie;
    logic [XLEN-1:0] exp_mepc;
    logic [XLEN-1:0] exp_mtvec;

    trap_ctrl_top #(
        .IRQ_ID_W    (IRQ_ID_W),
        .RESET_MTVEC (RESET_MTVEC)
    ) dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst_valid_i    (inst_valid_i),
        .pc_i            (pc_i),
        .jump_flag_i     (jump_flag_i),
        .jump_addr_i     (jump_addr_i),
        .ecall_i         (ecall_i),
        .ebreak_i        (ebreak_i),
        .mret_i          (mret_i),
        .atom_busy_i     (atom_busy_i),
        .irq_i           (irq_i),
        .irq_id_i        (irq_id_i),
        .wb_req_i        (wb_req),
        .wb_rsp_o        (wb_rsp),
        .flush_o         (flush),
        .stall_o         (stall),
        .redirect_o      (redirect),
        .redirect_addr_o (redirect_addr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(negedge clk) begin
        if (redirect) begin
            redirect_cnt++;
            last_redirect_addr = redirect_addr;
        end
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYC);
        $display("Checks failed");
        $finish;
    end

    // right-shifting galois form
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ 32'h8020_0003;
        return n;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    function automatic logic [31:0] mstatus_word(input logic mie, input logic mpie);
        return (32'(mpie) << 7) | (32'(mie) << 3);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else begin
            errors++;
            $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic report_stuck(input string what);
        hs_errors++;
        $display("%s did not happen within %0d cycles", what, WAIT_LIMIT);
    endtask

    task automatic bus_cycle(input logic we, input logic [CSR_ADDR_W-1:0] adr,
                             input logic [XLEN-1:0] wdata, output logic [XLEN-1:0] rdata);
        int n;
        n = 0;
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
        do begin
            @(negedge clk);
            n++;
        end while (!wb_rsp.ack && n < WAIT_LIMIT);
        flush_at_ack = flush;
        rdata        = wb_rsp.dat_r;
        if (!wb_rsp.ack) report_stuck("bus ack");
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic wb_write(input logic [CSR_ADDR_W-1:0] adr, input logic [XLEN-1:0] data);
        logic [XLEN-1:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [CSR_ADDR_W-1:0] adr, output logic [XLEN-1:0] data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    task automatic read_expect(input string name, input logic [CSR_ADDR_W-1:0] adr,
                               input logic [XLEN-1:0] exp);
        logic [XLEN-1:0] rd;
        wb_read(adr, rd);
        check_value(name, exp, rd);
    endtask

    task automatic release_requests();
        @(posedge clk);
        ecall_i     <= 1'b0;
        ebreak_i    <= 1'b0;
        mret_i      <= 1'b0;
        irq_i       <= 1'b0;
        jump_flag_i <= 1'b0;
    endtask

    task automatic wait_flush(input string name);
        int n;
        n = 0;
        while (!flush && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!flush) report_stuck({name, " flush"});
    endtask

    task automatic wait_redirect(input string name, output logic [XLEN-1:0] addr);
        int n;
        n = 0;
        while (!redirect && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        addr = redirect_addr;
        if (!redirect) report_stuck({name, " redirect"});
    endtask

    // run an already driven request to the redirect and update the model
    task automatic finish_trap(input string name, input logic [XLEN-1:0] epc);
        logic [XLEN-1:0] addr;
        wait_flush(name);
        release_requests();
        wait_redirect(name, addr);
        check_value({name, " redirect"}, exp_mtvec, addr);
        exp_mpie = exp_mie;
        exp_mie  = 1'b0;
        exp_mepc = epc;
    endtask

    task automatic check_trap_state(input string name, input logic [31:0] cause);
        read_expect({name, " mepc"}, CSR_MEPC, exp_mepc);
        read_expect({name, " mcause"}, CSR_MCAUSE, cause);
        read_expect({name, " mstatus"}, CSR_MSTATUS, mstatus_word(exp_mie, exp_mpie));
    endtask

    task automatic expect_no_flush(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value(name, 32'd0, 32'(flush));
        end
    endtask

    initial begin
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     jaddr;
        logic [XLEN-1:0]     addr;
        logic [XLEN-1:0]     old_mtvec;
        logic [IRQ_ID_W-1:0] id_a;
        logic [IRQ_ID_W-1:0] id_b;
        int                  rc0;

        rst_n        = 1'b0;
        inst_valid_i = 1'b0;
        pc_i         = '0;
        jump_flag_i  = 1'b0;
        jump_addr_i  = '0;
        ecall_i      = 1'b0;
        ebreak_i     = 1'b0;
        mret_i       = 1'b0;
        atom_busy_i  = 1'b0;
        irq_i        = 1'b0;
        irq_id_i     = '0;
        wb_req       = '0;
        errors       = 0;
        hs_errors    = 0;
        lfsr_q       = 32'h04a2_15a3;
        exp_mie      = 1'b0;
        exp_mpie     = 1'b0;
        exp_mepc     = '0;
        exp_mtvec    = RESET_MTVEC;
        repeat (4) @(posedge clk);
        rst_n        <= 1'b1;
        @(posedge clk);
        inst_valid_i <= 1'b1;

        // reset values
        read_expect("reset mstatus", CSR_MSTATUS, 32'd0);
        read_expect("reset mepc", CSR_MEPC, 32'd0);
        read_expect("reset mcause", CSR_MCAUSE, 32'd0);
        read_expect("reset mtvec", CSR_MTVEC, RESET_MTVEC);

        // ecall with a random pc
        exp_mtvec = 32'h8000_0040;
        wb_write(CSR_MTVEC, exp_mtvec);
        wb_write(CSR_MSTATUS, mstatus_word(1'b1, 1'b0));
        exp_mie  = 1'b1;
        exp_mpie = 1'b0;
        pc = take_bits(30) << 2;
        @(posedge clk);
        pc_i    <= pc;
        ecall_i <= 1'b1;
        finish_trap("ecall", pc);
        check_trap_state("ecall", 32'd11);

        // ebreak behind a taken jump
        pc    = take_bits(30) << 2;
        jaddr = take_bits(30) << 2;
        @(posedge clk);
        pc_i        <= pc;
        jump_flag_i <= 1'b1;
        jump_addr_i <= jaddr;
        ebreak_i    <= 1'b1;
        finish_trap("ebreak", jaddr - 32'd4);
        check_trap_state("ebreak", 32'd3);

        // ecall held off by the atomic unit
        pc = take_bits(30) << 2;
        @(posedge clk);
        pc_i        <= pc;
        atom_busy_i <= 1'b1;
        ecall_i     <= 1'b1;
        repeat (6) begin
            @(negedge clk);
            check_value("atomic stall", 32'd1, 32'(stall));
            check_value("atomic flush", 32'd0, 32'(flush));
        end
        @(posedge clk);
        atom_busy_i <= 1'b0;
        finish_trap("atomic", pc);
        check_trap_state("atomic", 32'd11);

        // a repeat of the running interrupt id is ignored
        wb_write(CSR_MSTATUS, mstatus_word(1'b1, 1'b0));
        exp_mie  = 1'b1;
        exp_mpie = 1'b0;
        id_a = IRQ_ID_W'(take_bits(IRQ_ID_W));
        id_b = IRQ_ID_W'(take_bits(IRQ_ID_W));
        if (id_b == id_a) id_b = id_a ^ 8'h01;
        pc = take_bits(30) << 2;
        @(posedge clk);
        pc_i     <= pc;
        irq_id_i <= id_a;
        irq_i    <= 1'b1;
        finish_trap("irq first", pc);
        check_trap_state("irq first", {1'b1, 31'(16 + id_a)});
        wb_write(CSR_MSTATUS, mstatus_word(1'b1, 1'b1));   // handler reenables
        exp_mie  = 1'b1;
        exp_mpie = 1'b1;
        @(posedge clk);
        irq_id_i <= id_a;
        irq_i    <= 1'b1;
        expect_no_flush("irq repeat flush", 8);
        pc = take_bits(30) << 2;
        @(posedge clk);
        pc_i     <= pc;
        irq_id_i <= id_b;
        finish_trap("irq nested", pc);
        check_trap_state("irq nested", {1'b1, 31'(16 + id_b)});

        // masked interrupt followed by mret
        wb_write(CSR_MSTATUS, mstatus_word(1'b0, 1'b1));
        exp_mie  = 1'b0;
        exp_mpie = 1'b1;
        @(posedge clk);
        irq_id_i <= id_a;
        irq_i    <= 1'b1;
        expect_no_flush("masked irq flush", 8);
        @(posedge clk);
        irq_i <= 1'b0;
        wb_write(CSR_MSTATUS, mstatus_word(1'b1, 1'b0));   // mret has to move both bits
        exp_mie  = 1'b1;
        exp_mpie = 1'b0;
        @(posedge clk);
        mret_i <= 1'b1;
        wait_flush("mret");
        release_requests();
        wait_redirect("mret", addr);
        check_value("mret redirect", exp_mepc, addr);
        exp_mie  = exp_mpie;
        exp_mpie = 1'b1;
        read_expect("mret mstatus", CSR_MSTATUS, mstatus_word(exp_mie, exp_mpie));

        // bus write issued in the middle of a trap sequence
        old_mtvec = exp_mtvec;
        pc = take_bits(30) << 2;
        @(posedge clk);
        pc_i    <= pc;
        ecall_i <= 1'b1;
        wait_flush("bus hold");
        rc0 = redirect_cnt;
        release_requests();
        wb_write(CSR_MTVEC, 32'h8000_0200);
        check_value("bus hold redirect count", 32'(rc0 + 1), 32'(redirect_cnt));
        check_value("bus hold redirect", old_mtvec, last_redirect_addr);
        check_value("bus hold flush at ack", 32'd0, 32'(flush_at_ack));
        exp_mpie  = exp_mie;
        exp_mie   = 1'b0;
        exp_mepc  = pc;
        exp_mtvec = 32'h8000_0200;
        read_expect("bus hold mtvec", CSR_MTVEC, exp_mtvec);
        check_trap_state("bus hold", 32'd11);

        repeat (3) @(posedge clk);
        $display("value errors: %0d, handshake errors: %0d, assertion failures: %0d",
                 errors, hs_errors, dut_i.chk_i.fail_cnt);
        if (errors == 0 && hs_errors == 0 && dut_i.chk_i.fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
